/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_dac_channel
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "simulation reported errors"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* logic/dac_chan_pkg.sv */
package dac_chan_pkg;

  // ********************
  // data widths
  // ********************

  // one signed DAC sample
  typedef logic signed [15:0] sample_t;

  // four samples with sample 0 in the low bits
  typedef logic [63:0] dac_word_t;

  // dds phase and phase increment
  typedef logic [15:0] phase_t;

  // tone scale as unsigned Q1.15
  typedef logic [15:0] scale_t;

  // register bus
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // ********************
  // source select
  // ********************

  // codes above 7 fall back to the dds
  typedef enum logic [3:0] {
    SEL_DDS      = 4'd0,
    SEL_PATTERN  = 4'd1,
    SEL_DMA      = 4'd2,
    SEL_ZERO     = 4'd3,
    SEL_PN7_INV  = 4'd4,
    SEL_PN15_INV = 4'd5,
    SEL_PN7      = 4'd6,
    SEL_PN15     = 4'd7
  } data_sel_e;

  // register word addresses
  localparam reg_addr_t REG_CTRL    = 8'h00;
  localparam reg_addr_t REG_TONE1   = 8'h02;
  localparam reg_addr_t REG_SCALE1  = 8'h03;
  localparam reg_addr_t REG_TONE2   = 8'h04;
  localparam reg_addr_t REG_SCALE2  = 8'h05;
  localparam reg_addr_t REG_PATTERN = 8'h06;
  localparam reg_addr_t REG_ID      = 8'h07;

  // phase update to sample at the dds output
  localparam int DDS_LATENCY = 3;

endpackage

/* logic/dac_chan_regs.sv */
module dac_chan_regs #(
  parameter logic [31:0] CHANNEL_ID = 32'h0
) (
  input  logic                   dac_clk,
  input  logic                   rst_n,

  // write port
  input  logic                   reg_wreq,
  input  dac_chan_pkg::reg_addr_t reg_waddr,
  input  dac_chan_pkg::reg_data_t reg_wdata,
  output logic                   reg_wack,

  // read port
  input  logic                   reg_rreq,
  input  dac_chan_pkg::reg_addr_t reg_raddr,
  output dac_chan_pkg::reg_data_t reg_rdata,
  output logic                   reg_rack,

  // controls to the datapath
  output dac_chan_pkg::data_sel_e data_sel,
  output logic                   format,
  output dac_chan_pkg::phase_t   tone1_init,
  output dac_chan_pkg::phase_t   tone1_incr,
  output dac_chan_pkg::phase_t   tone2_init,
  output dac_chan_pkg::phase_t   tone2_incr,
  output dac_chan_pkg::scale_t   tone1_scale,
  output dac_chan_pkg::scale_t   tone2_scale,
  output dac_chan_pkg::sample_t  pat1,
  output dac_chan_pkg::sample_t  pat2
);

  import dac_chan_pkg::*;

  // ********************
  // write decode
  // ********************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_wack    <= 1'b0;
      data_sel    <= SEL_DDS;
      format      <= 1'b0;
      tone1_init  <= '0;
      tone1_incr  <= '0;
      tone1_scale <= '0;
      tone2_init  <= '0;
      tone2_incr  <= '0;
      tone2_scale <= '0;
      pat1        <= '0;
      pat2        <= '0;
    end else begin
      reg_wack <= reg_wreq;
      if (reg_wreq) begin
        case (reg_waddr)
          REG_CTRL: begin
            data_sel <= data_sel_e'(reg_wdata[3:0]);
            format   <= reg_wdata[4];
          end
          REG_TONE1: begin
            tone1_init <= reg_wdata[31:16];
            tone1_incr <= reg_wdata[15:0];
          end
          REG_SCALE1: tone1_scale <= reg_wdata[15:0];
          REG_TONE2: begin
            tone2_init <= reg_wdata[31:16];
            tone2_incr <= reg_wdata[15:0];
          end
          REG_SCALE2: tone2_scale <= reg_wdata[15:0];
          REG_PATTERN: begin
            pat2 <= reg_wdata[31:16];
            pat1 <= reg_wdata[15:0];
          end
          // id and unmapped addresses ignore writes
          default: ;
        endcase
      end
    end
  end

  // ********************
  // read back
  // ********************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rack  <= 1'b0;
      reg_rdata <= '0;
    end else begin
      reg_rack <= reg_rreq;
      if (reg_rreq) begin
        case (reg_raddr)
          REG_CTRL:    reg_rdata <= {27'd0, format, data_sel};
          REG_TONE1:   reg_rdata <= {tone1_init, tone1_incr};
          REG_SCALE1:  reg_rdata <= {16'd0, tone1_scale};
          REG_TONE2:   reg_rdata <= {tone2_init, tone2_incr};
          REG_SCALE2:  reg_rdata <= {16'd0, tone2_scale};
          REG_PATTERN: reg_rdata <= {pat2, pat1};
          REG_ID:      reg_rdata <= CHANNEL_ID;
          default:     reg_rdata <= '0;
        endcase
      end
    end
  end

  // each request is a single-cycle pulse answered in the next cycle
  a_wack_timing: assert property (@(posedge dac_clk) disable iff (!rst_n)
    reg_wreq |=> reg_wack && !reg_wreq);
  a_rack_timing: assert property (@(posedge dac_clk) disable iff (!rst_n)
    reg_rreq |=> reg_rack && !reg_rreq);

endmodule

/* logic/dac_channel_top.sv */
module dac_channel_top #(
  parameter logic [31:0] CHANNEL_ID       = 32'h0,
  parameter bit          DATAPATH_DISABLE = 1'b0
) (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  logic                   data_sync,
  input  dac_chan_pkg::dac_word_t dma_data,

  // register bus
  input  logic                   reg_wreq,
  input  dac_chan_pkg::reg_addr_t reg_waddr,
  input  dac_chan_pkg::reg_data_t reg_wdata,
  output logic                   reg_wack,
  input  logic                   reg_rreq,
  input  dac_chan_pkg::reg_addr_t reg_raddr,
  output dac_chan_pkg::reg_data_t reg_rdata,
  output logic                   reg_rack,

  // dac side
  output dac_chan_pkg::dac_word_t dac_data,
  output logic                   dac_enable
);

  import dac_chan_pkg::*;

  data_sel_e data_sel;
  logic      format;
  phase_t    tone1_init;
  phase_t    tone1_incr;
  phase_t    tone2_init;
  phase_t    tone2_incr;
  scale_t    tone1_scale;
  scale_t    tone2_scale;
  sample_t   pat1;
  sample_t   pat2;
  dac_word_t pn7_word;
  dac_word_t pn15_word;
  dac_word_t dds_word;

  dac_chan_regs #(.CHANNEL_ID(CHANNEL_ID)) i_regs (
    .dac_clk     (dac_clk),
    .rst_n       (rst_n),
    .reg_wreq    (reg_wreq),
    .reg_waddr   (reg_waddr),
    .reg_wdata   (reg_wdata),
    .reg_wack    (reg_wack),
    .reg_rreq    (reg_rreq),
    .reg_raddr   (reg_raddr),
    .reg_rdata   (reg_rdata),
    .reg_rack    (reg_rack),
    .data_sel    (data_sel),
    .format      (format),
    .tone1_init  (tone1_init),
    .tone1_incr  (tone1_incr),
    .tone2_init  (tone2_init),
    .tone2_incr  (tone2_incr),
    .tone1_scale (tone1_scale),
    .tone2_scale (tone2_scale),
    .pat1        (pat1),
    .pat2        (pat2)
  );

  dac_pn_gen i_pn_gen (
    .dac_clk   (dac_clk),
    .rst_n     (rst_n),
    .data_sync (data_sync),
    .pn7_word  (pn7_word),
    .pn15_word (pn15_word)
  );

  dac_dds #(.DATAPATH_DISABLE(DATAPATH_DISABLE)) i_dds (
    .dac_clk     (dac_clk),
    .rst_n       (rst_n),
    .data_sync   (data_sync),
    .format      (format),
    .tone1_init  (tone1_init),
    .tone1_incr  (tone1_incr),
    .tone2_init  (tone2_init),
    .tone2_incr  (tone2_incr),
    .tone1_scale (tone1_scale),
    .tone2_scale (tone2_scale),
    .dds_word    (dds_word)
  );

  dac_data_select i_select (
    .dac_clk    (dac_clk),
    .rst_n      (rst_n),
    .data_sel   (data_sel),
    .dds_word   (dds_word),
    .pn7_word   (pn7_word),
    .pn15_word  (pn15_word),
    .dma_data   (dma_data),
    .pat1       (pat1),
    .pat2       (pat2),
    .dac_data   (dac_data),
    .dac_enable (dac_enable)
  );

endmodule

/* logic/dac_data_select.sv */
module dac_data_select (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  dac_chan_pkg::data_sel_e data_sel,
  input  dac_chan_pkg::dac_word_t dds_word,
  input  dac_chan_pkg::dac_word_t pn7_word,
  input  dac_chan_pkg::dac_word_t pn15_word,
  input  dac_chan_pkg::dac_word_t dma_data,
  input  dac_chan_pkg::sample_t  pat1,
  input  dac_chan_pkg::sample_t  pat2,
  output dac_chan_pkg::dac_word_t dac_data,
  output logic                   dac_enable
);

  import dac_chan_pkg::*;

  dac_word_t pat_word;

  // two samples repeated over the word
  assign pat_word = {pat2, pat1, pat2, pat1};

  // ********************
  // output register
  // ********************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      dac_data   <= '0;
      dac_enable <= 1'b0;
    end else begin
      // dma is the only source that pulls data
      dac_enable <= (data_sel == SEL_DMA);
      case (data_sel)
        SEL_PN15:     dac_data <= pn15_word;
        SEL_PN7:      dac_data <= pn7_word;
        SEL_PN15_INV: dac_data <= ~pn15_word;
        SEL_PN7_INV:  dac_data <= ~pn7_word;
        SEL_ZERO:     dac_data <= '0;
        SEL_DMA:      dac_data <= dma_data;
        SEL_PATTERN:  dac_data <= pat_word;
        default:      dac_data <= dds_word;
      endcase
    end
  end

endmodule

/* logic/dac_dds.sv */
module dac_dds #(
  parameter bit DATAPATH_DISABLE = 1'b0
) (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  logic                   data_sync,
  input  logic                   format,
  input  dac_chan_pkg::phase_t   tone1_init,
  input  dac_chan_pkg::phase_t   tone1_incr,
  input  dac_chan_pkg::phase_t   tone2_init,
  input  dac_chan_pkg::phase_t   tone2_incr,
  input  dac_chan_pkg::scale_t   tone1_scale,
  input  dac_chan_pkg::scale_t   tone2_scale,
  output dac_chan_pkg::dac_word_t dds_word
);

  import dac_chan_pkg::*;

  localparam int LANES = 4;

  // triangle in place of a sine table
  function automatic sample_t tri_amp(input phase_t p);
    phase_t f;
    f = p[15] ? ~p : p;
    f = {f[14:0], 1'b0};
    return sample_t'(f - 16'h8000);
  endfunction

  // Q1.15 scale, result kept at 17 bits for scales above one
  function automatic logic signed [16:0] scale_amp(input sample_t a, input scale_t s);
    logic signed [32:0] p;
    p = a * $signed({1'b0, s});
    return p[31:15];
  endfunction

  // halve the tone sum, optional offset binary
  function automatic sample_t mix(input logic signed [16:0] a,
                                  input logic signed [16:0] b,
                                  input logic               fmt);
    logic signed [17:0] s;
    sample_t            r;
    s = a + b;
    r = s[16:1];
    if (fmt) begin
      r[15] = ~r[15];
    end
    return r;
  endfunction

  phase_t             step1;
  phase_t             step2;
  phase_t             ph1  [LANES];
  phase_t             ph2  [LANES];
  sample_t            amp1 [LANES];
  sample_t            amp2 [LANES];
  logic signed [16:0] scl1 [LANES];
  logic signed [16:0] scl2 [LANES];

  // ********************
  // accumulators and pipeline
  // ********************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      step1    <= '0;
      step2    <= '0;
      dds_word <= '0;
      for (int k = 0; k < LANES; k++) begin
        ph1[k]  <= '0;
        ph2[k]  <= '0;
        amp1[k] <= '0;
        amp2[k] <= '0;
        scl1[k] <= '0;
        scl2[k] <= '0;
      end
    end else begin
      if (data_sync) begin
        // lane k starts k increments ahead, each lane then steps by four
        step1 <= {tone1_incr[13:0], 2'b00};
        step2 <= {tone2_incr[13:0], 2'b00};
        for (int k = 0; k < LANES; k++) begin
          ph1[k] <= tone1_init + phase_t'(k) * tone1_incr;
          ph2[k] <= tone2_init + phase_t'(k) * tone2_incr;
        end
      end else begin
        for (int k = 0; k < LANES; k++) begin
          ph1[k] <= ph1[k] + step1;
          ph2[k] <= ph2[k] + step2;
        end
      end

      // stage 1 amplitude, stage 2 scale
      for (int k = 0; k < LANES; k++) begin
        amp1[k] <= tri_amp(ph1[k]);
        amp2[k] <= tri_amp(ph2[k]);
        scl1[k] <= scale_amp(amp1[k], tone1_scale);
        scl2[k] <= scale_amp(amp2[k], tone2_scale);
      end

      // stage 3 sum and format
      if (data_sync || DATAPATH_DISABLE) begin
        dds_word <= '0;
      end else begin
        for (int k = 0; k < LANES; k++) begin
          dds_word[16*k +: 16] <= mix(scl1[k], scl2[k], format);
        end
      end
    end
  end

endmodule

/* logic/dac_pn_gen.sv */
module dac_pn_gen (
  input  logic                   dac_clk,
  input  logic                   rst_n,
  input  logic                   data_sync,
  output dac_chan_pkg::dac_word_t pn7_word,
  output dac_chan_pkg::dac_word_t pn15_word
);

  import dac_chan_pkg::*;

  // ********************
  // lfsr unroll
  // ********************

  // runs 64 steps of a fibonacci lfsr with taps at len-1 and len-2;
  // hist[0] is the newest bit, only the low len bits matter
  function automatic dac_word_t pn_step(input logic [14:0] hist, input int len);
    logic [14:0] h;
    logic        nb;
    dac_word_t   w;
    h = hist;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      nb = h[len-1] ^ h[len-2];
      h  = {h[13:0], nb};
      // oldest bit lands in bit 15 of sample 0
      w[16*(i/16) + 15 - (i%16)] = nb;
    end
    return w;
  endfunction

  dac_word_t pn7_next;
  dac_word_t pn15_next;

  // newest bit of a word sits in bit 0 of sample 3
  assign pn7_next  = pn_step({8'd0, pn7_word[54:48]}, 7);
  assign pn15_next = pn_step(pn15_word[62:48], 15);

  // ********************
  // sequence state
  // ********************

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      pn7_word  <= '1;
      pn15_word <= '1;
    end else if (data_sync) begin
      // restart in step with the dds
      pn7_word  <= '1;
      pn15_word <= '1;
    end else begin
      pn7_word  <= pn7_next;
      pn15_word <= pn15_next;
    end
  end

  // the all-zero state would lock both sequences
  a_pn_nonzero: assert property (@(posedge dac_clk) disable iff (!rst_n)
    (pn7_word != '0) && (pn15_word != '0));

endmodule

/* tb.f */
logic/dac_chan_pkg.sv
logic/dac_chan_regs.sv
logic/dac_pn_gen.sv
logic/dac_dds.sv
logic/dac_data_select.sv
logic/dac_channel_top.sv
testbench/tb_dac_channel.sv

/* testbench/dac_channel_tests.txt */
# W addr data | R addr expected | S sync cycles (decimal) | C kind count(decimal) word
# kind: F word from this file, M dma passthrough, P pn model, D dds model
R 07 00009152
R 3C 00000000
W 02 F0001234
W 03 00006000
W 04 40000B00
W 05 00002000
W 06 A5A55A5A
R 02 F0001234
R 03 00006000
R 04 40000B00
R 05 00002000
R 06 A5A55A5A
W 07 FFFFFFFF
R 07 00009152
W 00 00000003
R 00 00000003
C F 6 0000000000000000
W 00 00000001
C F 6 A5A55A5AA5A55A5A
W 00 00000002
C M 10 0
W 00 00000006
S 3
C P 12 0
W 00 00000007
S 2
C P 12 0
W 00 00000004
S 2
C P 8 0
W 00 00000005
S 1
C P 8 0
W 00 00000000
S 2
C D 24 0
W 00 00000010
R 00 00000010
S 2
C D 24 0
W 00 00000008
S 2
C D 8 0

/* testbench/tb_dac_channel.sv */
module tb_dac_channel;
  timeunit 1ns;
  timeprecision 100ps;

  import dac_chan_pkg::*;

  localparam logic [31:0] CHANNEL_ID  = 32'h0000_9152;
  localparam int          ACK_TIMEOUT = 16;
  localparam string       TESTS_FILE  = "testbench/dac_channel_tests.txt";

  logic      dac_clk = 1'b0;
  logic      rst_n;
  logic      data_sync;
  dac_word_t dma_data = '0;
  dac_word_t dma_prev = '0;
  logic      reg_wreq, reg_wack, reg_rreq, reg_rack;
  reg_addr_t reg_waddr, reg_raddr;
  reg_data_t reg_wdata, reg_rdata;
  dac_word_t dac_data;
  logic      dac_enable;

  // register contents as last written for the models
  data_sel_e cur_sel;
  logic      cur_fmt;
  phase_t    t1_init, t1_incr, t2_init, t2_incr;
  scale_t    t1_scale, t2_scale;

  // last len bits of each sequence with the oldest first
  bit pn7_q[$];
  bit pn15_q[$];

  dac_channel_top #(.CHANNEL_ID(CHANNEL_ID), .DATAPATH_DISABLE(1'b0)) DUT (.*);

  always #2 dac_clk = ~dac_clk;

  // fresh dma word every cycle and the previous one for the passthrough check
  always @(posedge dac_clk) begin
    dma_prev <= dma_data;
    dma_data <= {$urandom, $urandom};
  end

  // ********************
  // error handling
  // ********************

  task automatic stop_with_failure();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string msg);
    $display("[FAIL] %0t ns: %s", $time, msg);
    stop_with_failure();
  endtask

  // ********************
  // reference models
  // ********************

  task automatic restart_pn_model();
    pn7_q.delete();
    pn15_q.delete();
    repeat (7) pn7_q.push_back(1'b1);
    repeat (15) pn15_q.push_back(1'b1);
  endtask

  // taps x^len and x^(len-1) are the two oldest bits held
  task automatic next_pn_words(output dac_word_t w7, output dac_word_t w15);
    bit          b7;
    bit          b15;
    logic [15:0] acc7;
    logic [15:0] acc15;
    acc7 = '0;
    acc15 = '0;
    for (int i = 0; i < 64; i++) begin
      b7 = pn7_q[0] ^ pn7_q[1];
      b15 = pn15_q[0] ^ pn15_q[1];
      pn7_q.push_back(b7);
      pn7_q.delete(0);
      pn15_q.push_back(b15);
      pn15_q.delete(0);
      // first bit of a sample ends up in its msb
      acc7 = {acc7[14:0], b7};
      acc15 = {acc15[14:0], b15};
      if (i % 16 == 15) begin
        w7[16*(i/16) +: 16] = acc7;
        w15[16*(i/16) +: 16] = acc15;
      end
    end
  endtask

  function automatic int triangle(input phase_t p);
    logic [15:0] fold;
    fold = p[15] ? ~p : p;
    fold = fold << 1;
    return int'(fold) - 32768;
  endfunction

  // lane k of word idx sits at phase init + (4*idx + k)*incr
  function automatic dac_word_t dds_model_word(input int idx);
    dac_word_t   w;
    phase_t      p1, p2;
    longint      s1, s2, sum;
    logic [15:0] smp;
    w = '0;
    for (int k = 0; k < 4; k++) begin
      p1 = t1_init + phase_t'(4 * idx + k) * t1_incr;
      p2 = t2_init + phase_t'(4 * idx + k) * t2_incr;
      s1 = (longint'(triangle(p1)) * longint'(t1_scale)) >>> 15;
      s2 = (longint'(triangle(p2)) * longint'(t2_scale)) >>> 15;
      sum = (s1 + s2) >>> 1;
      smp = sum[15:0];
      if (cur_fmt) begin
        smp[15] = ~smp[15];
      end
      w[16*k +: 16] = smp;
    end
    return w;
  endfunction

  // ********************
  // bus and stimulus
  // ********************

  task automatic wait_ack(input bit is_read, output int lag);
    bit seen;
    seen = 1'b0;
    lag = 0;
    while (!seen && lag < ACK_TIMEOUT) begin
      @(negedge dac_clk);
      lag++;
      seen = is_read ? reg_rack : reg_wack;
    end
    if (!seen) begin
      $display("no %s acknowledge within %0d cycles", is_read ? "read" : "write", ACK_TIMEOUT);
      stop_with_failure();
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    int lag;
    @(posedge dac_clk);
    reg_wreq <= 1'b1;
    reg_waddr <= addr;
    reg_wdata <= data;
    @(posedge dac_clk);
    reg_wreq <= 1'b0;
    wait_ack(1'b0, lag);
    assert (lag == 1)
      else report_mismatch($sformatf("write ack at 0x%02h after %0d cycles", addr, lag));
    case (addr)
      REG_CTRL: begin
        cur_sel = data_sel_e'(data[3:0]);
        cur_fmt = data[4];
      end
      REG_TONE1: begin
        t1_init = data[31:16];
        t1_incr = data[15:0];
      end
      REG_SCALE1: t1_scale = data[15:0];
      REG_TONE2: begin
        t2_init = data[31:16];
        t2_incr = data[15:0];
      end
      REG_SCALE2: t2_scale = data[15:0];
      default: ;
    endcase
  endtask

  task automatic read_reg(input reg_addr_t addr, input reg_data_t expected);
    int lag;
    @(posedge dac_clk);
    reg_rreq <= 1'b1;
    reg_raddr <= addr;
    @(posedge dac_clk);
    reg_rreq <= 1'b0;
    wait_ack(1'b1, lag);
    assert (lag == 1)
      else report_mismatch($sformatf("read ack at 0x%02h after %0d cycles", addr, lag));
    assert (reg_rdata == expected)
      else report_mismatch($sformatf("reg 0x%02h read %h, expected %h",
                                     addr, reg_rdata, expected));
  endtask

  // returns on the edge where sync goes low
  task automatic run_sync(input int cycles);
    @(posedge dac_clk);
    data_sync <= 1'b1;
    repeat (cycles) @(posedge dac_clk);
    data_sync <= 1'b0;
    restart_pn_model();
  endtask

  task automatic check_source(input logic [7:0] kind, input int count, input dac_word_t fixed);
    int        skip;
    dac_word_t exp;
    dac_word_t w7;
    dac_word_t w15;
    skip = (kind == "P") ? 1 : (kind == "D") ? DDS_LATENCY : 0;
    repeat (skip) @(posedge dac_clk);
    for (int i = 0; i < count; i++) begin
      @(posedge dac_clk);
      @(negedge dac_clk);
      case (kind)
        "P": begin
          next_pn_words(w7, w15);
          case (cur_sel)
            SEL_PN7:      exp = w7;
            SEL_PN15:     exp = w15;
            SEL_PN7_INV:  exp = ~w7;
            SEL_PN15_INV: exp = ~w15;
            default:      exp = '0;
          endcase
        end
        "D":     exp = dds_model_word(i);
        "M":     exp = dma_prev;
        default: exp = fixed;
      endcase
      assert (dac_data == exp)
        else report_mismatch($sformatf("source %c word %0d: dac_data %h, expected %h",
                                       kind, i, dac_data, exp));
      assert (dac_enable == (cur_sel == SEL_DMA))
        else report_mismatch($sformatf("dac_enable %b with select %0d", dac_enable, cur_sel));
    end
  endtask

  // ********************
  // command player
  // ********************

  initial begin
    int          fd;
    string       line;
    logic [7:0]  cmd;
    logic [7:0]  kind;
    reg_addr_t   addr;
    reg_data_t   data;
    int          count;
    dac_word_t   word;
    void'($urandom(22));
    rst_n = 1'b0;
    data_sync = 1'b0;
    reg_wreq = 1'b0;
    reg_waddr = '0;
    reg_wdata = '0;
    reg_rreq = 1'b0;
    reg_raddr = '0;
    cur_sel = SEL_DDS;
    cur_fmt = 1'b0;
    t1_init = '0;
    t1_incr = '0;
    t2_init = '0;
    t2_incr = '0;
    t1_scale = '0;
    t2_scale = '0;
    restart_pn_model();
    repeat (16) @(posedge dac_clk);
    rst_n <= 1'b1;
    @(negedge dac_clk);
    assert (dac_data == '0 && !dac_enable)
      else report_mismatch("dac outputs not zero after reset");

    fd = $fopen(TESTS_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the command file %s", TESTS_FILE);
      stop_with_failure();
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line[0] == "#") continue;
      void'($sscanf(line, "%c", cmd));
      case (cmd)
        "W": begin
          void'($sscanf(line, "%c %h %h", cmd, addr, data));
          write_reg(addr, data);
        end
        "R": begin
          void'($sscanf(line, "%c %h %h", cmd, addr, data));
          read_reg(addr, data);
        end
        "S": begin
          void'($sscanf(line, "%c %d", cmd, count));
          run_sync(count);
        end
        "C": begin
          void'($sscanf(line, "%c %c %d %h", cmd, kind, count, word));
          check_source(kind, count, word);
        end
        default: begin
          $display("unknown command in %s: %s", TESTS_FILE, line);
          stop_with_failure();
        end
      endcase
    end
    $fclose(fd);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule
